//--- hdl/fixedPkg.sv
/* Fixed-point formats for the shade stage
   Q1.14 for unit vectors and lighting factors, Q16.16 for positions and directions */
package fixedPkg;

    // --------------------
    // Formats
    // --------------------
    localparam int normFracBits  = 14;
    localparam int fixedFracBits = 16;

    // Normals, light direction, lighting factor
    typedef logic signed [15:0] fixedNormT;

    // Hit positions, view and bounce directions
    typedef logic signed [31:0] fixedT;

    typedef struct packed {
        fixedNormT x;
        fixedNormT y;
        fixedNormT z;
    } fixedNorm3T;

    typedef struct packed {
        fixedT x;
        fixedT y;
        fixedT z;
    } fixed3T;

    // --------------------
    // Constants
    // --------------------
    // 1.0 in Q1.14
    localparam fixedNormT normOne = 16'sd16384;

    // Ambient light, roughly 0.3
    localparam fixedNormT ambientLevel = 16'sd4915;

endpackage

//--- hdl/shadePkg.sv
/* Shade stage records
   Fragment, render state, lane, sideband and output types plus pipeline depths */
package shadePkg;

    // --------------------
    // Pipeline depths
    // --------------------
    localparam int numChannels  = 3;
    // One quotient bit per stage, also the width of the bounce-weighted total
    localparam int divStages    = 12;
    localparam int laneLatency  = 1 + divStages;
    localparam int shadeLatency = 1 + laneLatency + 1;

    // --------------------
    // Basic types
    // --------------------
    typedef logic [numChannels-1:0][7:0] rgb8T;

    typedef enum logic [1:0] {
        surfaceNone,
        surfaceDiffuse,
        surfaceMetal,
        surfaceDielectric
    } surfaceT;

    typedef logic [3:0] bounceLevelT;

    // Hit record coming in from the shadow stage
    typedef struct packed {
        logic [9:0]          x;
        logic [9:0]          y;
        surfaceT             surface;
        logic                shadow;
        fixedPkg::fixedNorm3T normal;
        fixedPkg::fixed3T    viewDir;
        fixedPkg::fixed3T    hitPos;
        rgb8T                color;
        rgb8T                lastColor;
        bounceLevelT         bounceLevel;
        logic [15:0]         primIndex;
    } shadeFragmentT;

    typedef struct packed {
        fixedPkg::fixedNorm3T lightDir;
        bounceLevelT          maxBounceLevel;
    } renderStateT;

    // One color channel's work item
    typedef struct packed {
        fixedPkg::fixedNormT factor;
        logic [7:0]          material;
        logic [7:0]          last;
        bounceLevelT         bounceLevel;
    } laneInT;

    // Everything the output stage needs besides the colors
    typedef struct packed {
        logic [9:0]       x;
        logic [9:0]       y;
        logic [15:0]      primIndex;
        logic             isBounce;
        bounceLevelT      bounceLevel;
        fixedPkg::fixed3T hitPos;
        fixedPkg::fixed3T reflectDir;
    } sidebandT;

    // --------------------
    // Outputs
    // --------------------
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        rgb8T       color;
    } pixelOutT;

    typedef struct packed {
        logic [9:0]       x;
        logic [9:0]       y;
        rgb8T             lastColor;
        bounceLevelT      bounceLevel;
        fixedPkg::fixed3T orig;
        fixedPkg::fixed3T dir;
        logic [15:0]      primIndex;
    } bounceRayT;

endpackage

//--- hdl/surfaceLight.sv
/* Surface lighting: diffuse factor, mirror direction and bounce decision
   Registered once, feeds the color lanes and the sideband */
`timescale 1ns/10ps

module surfaceLight (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    inStrobe,
    input  shadePkg::shadeFragmentT fragment,
    input  shadePkg::renderStateT   renderState,
    output logic                    laneStrobe,
    output shadePkg::laneInT        laneIn [shadePkg::numChannels],
    output shadePkg::sidebandT      sideband
);

    logic signed [33:0]   dotSum;
    logic signed [19:0]   diffuse;
    logic signed [19:0]   litLevel;
    fixedPkg::fixedNormT  litFactor;
    fixedPkg::fixedNormT  factor;
    fixedPkg::fixed3T     normalWide;
    logic signed [65:0]   viewDot;
    fixedPkg::fixedT      twoDot;
    fixedPkg::fixed3T     mirrorDir;
    logic                 bounceNow;

    // v - k*n on one axis, product back in Q16.16
    function automatic fixedPkg::fixedT reflectAxis(
        input fixedPkg::fixedT v,
        input fixedPkg::fixedT n,
        input fixedPkg::fixedT k
    );
        logic signed [63:0] prod;
        prod = k * n;
        return v - fixedPkg::fixedT'(prod >>> fixedPkg::fixedFracBits);
    endfunction

    // --------------------
    // Diffuse factor
    // --------------------
    always_comb begin
        dotSum = fragment.normal.x * renderState.lightDir.x
               + fragment.normal.y * renderState.lightDir.y
               + fragment.normal.z * renderState.lightDir.z;
        diffuse = dotSum[fixedPkg::normFracBits +: 20];

        // Shadowed or facing away, ambient only
        if (fragment.shadow || diffuse < 0) begin
            diffuse = '0;
        end
        litLevel = diffuse + 20'(fixedPkg::ambientLevel);

        // Misses show the plain background color
        if (fragment.surface == shadePkg::surfaceNone ||
            litLevel > 20'(fixedPkg::normOne)) begin
            litFactor = fixedPkg::normOne;
        end else begin
            litFactor = litLevel[15:0];
        end

        // Metal keeps a quarter, the rest comes from the bounce
        if (fragment.surface == shadePkg::surfaceMetal) begin
            factor = litFactor >>> 2;
        end else begin
            factor = litFactor;
        end
    end

    // --------------------
    // Mirror direction
    // --------------------
    always_comb begin
        // Q1.14 normal into Q16.16
        normalWide.x = fixedPkg::fixedT'(fragment.normal.x) <<< 2;
        normalWide.y = fixedPkg::fixedT'(fragment.normal.y) <<< 2;
        normalWide.z = fixedPkg::fixedT'(fragment.normal.z) <<< 2;

        viewDot = normalWide.x * fragment.viewDir.x
                + normalWide.y * fragment.viewDir.y
                + normalWide.z * fragment.viewDir.z;
        twoDot = viewDot[fixedPkg::fixedFracBits +: 32] <<< 1;

        mirrorDir.x = reflectAxis(fragment.viewDir.x, normalWide.x, twoDot);
        mirrorDir.y = reflectAxis(fragment.viewDir.y, normalWide.y, twoDot);
        mirrorDir.z = reflectAxis(fragment.viewDir.z, normalWide.z, twoDot);
    end

    assign bounceNow = fragment.surface == shadePkg::surfaceMetal &&
                       fragment.bounceLevel < renderState.maxBounceLevel;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            laneStrobe <= 1'b0;
        end else begin
            laneStrobe <= inStrobe;
        end
    end

    always_ff @(posedge clk) begin
        if (inStrobe) begin
            for (int c = 0; c < shadePkg::numChannels; c++) begin
                laneIn[c].factor      <= factor;
                laneIn[c].material    <= fragment.color[c];
                laneIn[c].last        <= fragment.lastColor[c];
                laneIn[c].bounceLevel <= fragment.bounceLevel;
            end
            sideband.x           <= fragment.x;
            sideband.y           <= fragment.y;
            sideband.primIndex   <= fragment.primIndex;
            sideband.isBounce    <= bounceNow;
            sideband.bounceLevel <= fragment.bounceLevel;
            sideband.hitPos      <= fragment.hitPos;
            sideband.reflectDir  <= mirrorDir;
        end
    end

    // A bounce leaves room for the output stage to add one
    bounceLevelRoom: assert property (@(posedge clk) disable iff (!resetn)
        (inStrobe && bounceNow) |=> sideband.bounceLevel != 4'hf);

endmodule

//--- hdl/colorLane.sv
/* Color lane: current channel value, bounce-weighted total and a
   pipelined restoring divide by the number of bounces so far */
`timescale 1ns/10ps

module colorLane (
    input  logic             clk,
    input  logic             resetn,
    input  logic             laneStrobe,
    input  shadePkg::laneInT laneIn,
    output logic             chanStrobe,
    output logic [7:0]       chanOut
);

    // Dividend shifts out at the top while quotient bits shift in below
    typedef struct packed {
        logic [shadePkg::divStages-1:0] num;
        logic [4:0]                     rem;
        logic [4:0]                     divisor;
    } divStageT;

    logic [23:0]                    product;
    logic [7:0]                     current;
    logic [shadePkg::divStages-1:0] total;
    divStageT                       stage [shadePkg::divStages+1];
    divStageT                       stepOut [shadePkg::divStages];
    logic [5:0]                     trial [shadePkg::divStages];
    logic                           valid [shadePkg::divStages+1];

    // --------------------
    // Product stage
    // --------------------
    always_comb begin
        // Factor is never negative here
        product = laneIn.factor[14:0] * laneIn.material;
        current = product[fixedPkg::normFracBits +: 8];
        total   = laneIn.last * laneIn.bounceLevel + current;
    end

    // --------------------
    // Divider steps
    // --------------------
    always_comb begin
        for (int s = 0; s < shadePkg::divStages; s++) begin
            trial[s] = {stage[s].rem, stage[s].num[shadePkg::divStages-1]};
            stepOut[s].divisor = stage[s].divisor;
            if (trial[s] >= 6'(stage[s].divisor)) begin
                stepOut[s].rem = 5'(trial[s] - 6'(stage[s].divisor));
                stepOut[s].num = {stage[s].num[shadePkg::divStages-2:0], 1'b1};
            end else begin
                stepOut[s].rem = trial[s][4:0];
                stepOut[s].num = {stage[s].num[shadePkg::divStages-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int s = 0; s <= shadePkg::divStages; s++) begin
                valid[s] <= 1'b0;
            end
        end else begin
            valid[0] <= laneStrobe;
            for (int s = 0; s < shadePkg::divStages; s++) begin
                valid[s+1] <= valid[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        stage[0].num     <= total;
        stage[0].rem     <= '0;
        stage[0].divisor <= {1'b0, laneIn.bounceLevel} + 5'd1;
        for (int s = 0; s < shadePkg::divStages; s++) begin
            stage[s+1] <= stepOut[s];
        end
    end

    assign chanStrobe = valid[shadePkg::divStages];
    assign chanOut    = stage[shadePkg::divStages].num[7:0];

    // Averaging keeps the result within one channel
    quotientFits: assert property (@(posedge clk) disable iff (!resetn)
        chanStrobe |-> stage[shadePkg::divStages].num[shadePkg::divStages-1:8] == '0);

endmodule

//--- hdl/shadeOutput.sv
/* Shade output: delays the sideband to meet the lanes, then
   registers a finished pixel or a bounce ray */
`timescale 1ns/10ps

module shadeOutput (
    input  logic                clk,
    input  logic                resetn,
    input  shadePkg::sidebandT  sideband,
    input  logic                sidebandStrobe,
    input  logic                chanStrobe [shadePkg::numChannels],
    input  logic [7:0]          chanOut [shadePkg::numChannels],
    output logic                outValid,
    output logic                bounceValid,
    output shadePkg::pixelOutT  pixel,
    output shadePkg::bounceRayT bounce
);

    shadePkg::sidebandT               sbLine [shadePkg::laneLatency];
    logic                             sbValid [shadePkg::laneLatency];
    shadePkg::sidebandT               sbTail;
    logic                             tailValid;
    shadePkg::rgb8T                   laneColor;
    logic [shadePkg::numChannels-1:0] laneValid;

    assign sbTail    = sbLine[shadePkg::laneLatency-1];
    assign tailValid = sbValid[shadePkg::laneLatency-1];

    always_comb begin
        for (int c = 0; c < shadePkg::numChannels; c++) begin
            laneColor[c] = chanOut[c];
            laneValid[c] = chanStrobe[c];
        end
    end

    // --------------------
    // Sideband delay line
    // --------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < shadePkg::laneLatency; i++) begin
                sbValid[i] <= 1'b0;
            end
            outValid    <= 1'b0;
            bounceValid <= 1'b0;
        end else begin
            sbValid[0] <= sidebandStrobe;
            for (int i = 1; i < shadePkg::laneLatency; i++) begin
                sbValid[i] <= sbValid[i-1];
            end
            outValid    <= tailValid && !sbTail.isBounce;
            bounceValid <= tailValid && sbTail.isBounce;
        end
    end

    always_ff @(posedge clk) begin
        sbLine[0] <= sideband;
        for (int i = 1; i < shadePkg::laneLatency; i++) begin
            sbLine[i] <= sbLine[i-1];
        end

        // --------------------
        // Output records
        // --------------------
        if (tailValid && !sbTail.isBounce) begin
            pixel.x     <= sbTail.x;
            pixel.y     <= sbTail.y;
            pixel.color <= laneColor;
        end
        if (tailValid && sbTail.isBounce) begin
            bounce.x           <= sbTail.x;
            bounce.y           <= sbTail.y;
            bounce.lastColor   <= laneColor;
            bounce.bounceLevel <= sbTail.bounceLevel + 4'd1;
            bounce.orig        <= sbTail.hitPos;
            bounce.dir         <= sbTail.reflectDir;
            bounce.primIndex   <= sbTail.primIndex;
        end
    end

    // Lanes and delay line stay in step
    lanesAligned: assert property (@(posedge clk) disable iff (!resetn)
        laneValid == {shadePkg::numChannels{tailValid}});

    oneOutputKind: assert property (@(posedge clk) disable iff (!resetn)
        !(outValid && bounceValid));

endmodule

//--- hdl/shadeTop.sv
/* Shade stage top
   Lighting feeder, one divider lane per color channel and the output stage */
`timescale 1ns/10ps

module shadeTop (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    inStrobe,
    input  shadePkg::shadeFragmentT fragment,
    input  shadePkg::renderStateT   renderState,
    output logic                    outValid,
    output logic                    bounceValid,
    output shadePkg::pixelOutT      pixel,
    output shadePkg::bounceRayT     bounce
);

    logic               laneStrobe;
    shadePkg::laneInT   laneIn [shadePkg::numChannels];
    shadePkg::sidebandT sideband;
    logic               chanStrobe [shadePkg::numChannels];
    logic [7:0]         chanOut [shadePkg::numChannels];

    surfaceLight lightStage (
        .clk         (clk),
        .resetn      (resetn),
        .inStrobe    (inStrobe),
        .fragment    (fragment),
        .renderState (renderState),
        .laneStrobe  (laneStrobe),
        .laneIn      (laneIn),
        .sideband    (sideband)
    );

    // One lane per channel, all in lockstep
    for (genvar c = 0; c < shadePkg::numChannels; c++) begin : laneGen
        colorLane lane (
            .clk        (clk),
            .resetn     (resetn),
            .laneStrobe (laneStrobe),
            .laneIn     (laneIn[c]),
            .chanStrobe (chanStrobe[c]),
            .chanOut    (chanOut[c])
        );
    end

    shadeOutput outStage (
        .clk            (clk),
        .resetn         (resetn),
        .sideband       (sideband),
        .sidebandStrobe (laneStrobe),
        .chanStrobe     (chanStrobe),
        .chanOut        (chanOut),
        .outValid       (outValid),
        .bounceValid    (bounceValid),
        .pixel          (pixel),
        .bounce         (bounce)
    );

endmodule

//--- dv/clockGen.sv
/* Testbench clock and reset, 10 ns period, reset held for 3 cycles */
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
    end

endmodule

//--- dv/shadeModel.svh
/* Shade stage reference model
   LFSR step, unit vector table and expected output of one fragment */
`ifndef SHADE_MODEL_SVH
`define SHADE_MODEL_SVH

// Expected output of one fragment, with the cycle it is due
typedef struct packed {
    logic                isBounce;
    shadePkg::pixelOutT  pixel;
    shadePkg::bounceRayT bounce;
    int                  dueCycle;
} expectedT;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Unit vectors in Q1.14
function automatic fixedPkg::fixedNorm3T unitVector(input int idx);
    fixedPkg::fixedNorm3T v;
    case (idx)
        0:       v = '{16'sd16384, 16'sd0, 16'sd0};
        1:       v = '{-16'sd16384, 16'sd0, 16'sd0};
        2:       v = '{16'sd0, 16'sd16384, 16'sd0};
        3:       v = '{16'sd0, 16'sd0, -16'sd16384};
        4:       v = '{16'sd11585, 16'sd11585, 16'sd0};
        5:       v = '{-16'sd11585, 16'sd0, 16'sd11585};
        6:       v = '{16'sd9459, 16'sd9459, 16'sd9459};
        default: v = '{16'sd9459, -16'sd9459, 16'sd9459};
    endcase
    return v;
endfunction

function automatic expectedT shadeModel(
    input shadePkg::shadeFragmentT f,
    input shadePkg::renderStateT   rs
);
    expectedT       e;
    longint         d;
    longint         fct;
    longint         cur;
    longint         total;
    longint         twoDot;
    longint         n [3];
    longint         v [3];
    shadePkg::rgb8T col;
    e = '0;

    // Diffuse factor
    d = (longint'(f.normal.x) * rs.lightDir.x + longint'(f.normal.y) * rs.lightDir.y
        + longint'(f.normal.z) * rs.lightDir.z) >>> fixedPkg::normFracBits;
    if (f.shadow || d < 0) begin
        d = 0;
    end
    fct = d + fixedPkg::ambientLevel;
    if (f.surface == shadePkg::surfaceNone || fct > fixedPkg::normOne) begin
        fct = fixedPkg::normOne;
    end
    if (f.surface == shadePkg::surfaceMetal) begin
        fct = fct >>> 2;
    end

    // Scale and average each channel
    for (int c = 0; c < shadePkg::numChannels; c++) begin
        cur   = (fct * longint'(f.color[c])) >>> fixedPkg::normFracBits;
        total = longint'(f.lastColor[c]) * longint'(f.bounceLevel) + cur;
        col[c] = 8'(total / (longint'(f.bounceLevel) + 1));
    end

    // Mirror direction, normal moved into Q16.16
    n[0] = longint'(f.normal.x) * 4;
    n[1] = longint'(f.normal.y) * 4;
    n[2] = longint'(f.normal.z) * 4;
    v[0] = longint'(f.viewDir.x);
    v[1] = longint'(f.viewDir.y);
    v[2] = longint'(f.viewDir.z);
    twoDot = 2 * ((n[0] * v[0] + n[1] * v[1] + n[2] * v[2]) >>> fixedPkg::fixedFracBits);

    e.isBounce = f.surface == shadePkg::surfaceMetal && f.bounceLevel < rs.maxBounceLevel;
    if (e.isBounce) begin
        e.bounce.x           = f.x;
        e.bounce.y           = f.y;
        e.bounce.lastColor   = col;
        e.bounce.bounceLevel = f.bounceLevel + 4'd1;
        e.bounce.orig        = f.hitPos;
        e.bounce.dir.x       = 32'(v[0] - ((twoDot * n[0]) >>> fixedPkg::fixedFracBits));
        e.bounce.dir.y       = 32'(v[1] - ((twoDot * n[1]) >>> fixedPkg::fixedFracBits));
        e.bounce.dir.z       = 32'(v[2] - ((twoDot * n[2]) >>> fixedPkg::fixedFracBits));
        e.bounce.primIndex   = f.primIndex;
    end else begin
        e.pixel.x     = f.x;
        e.pixel.y     = f.y;
        e.pixel.color = col;
    end
    return e;
endfunction

`endif

//--- dv/shadeTb.sv
/* Shade stage testbench
   Directed and random fragments against the reference model, in order and on time */
`timescale 1ns/10ps

module shadeTb;

    `include "shadeModel.svh"

    localparam int clkPeriodNs   = 10;
    localparam int leadCycles    = 8;
    localparam int directedCount = 10;
    localparam int burstLength   = 150;
    localparam int mixedSlots    = 200;
    localparam int stimSlots     = leadCycles + directedCount + burstLength + mixedSlots;
    localparam int watchdogNs    = (stimSlots + shadePkg::shadeLatency + 20) * clkPeriodNs;

    logic                    clk;
    logic                    resetn;
    logic                    inStrobe;
    shadePkg::shadeFragmentT fragment;
    shadePkg::renderStateT   renderState;
    logic                    outValid;
    logic                    bounceValid;
    shadePkg::pixelOutT      pixel;
    shadePkg::bounceRayT     bounce;

    logic [31:0] lfsrState = 32'h9fbd;
    int          cycleCount = 0;
    expectedT    expQ [$];
    expectedT    gotExp;

    clockGen clockGen0 (.clk(clk), .resetn(resetn));

    shadeTop dut0 (
        .clk         (clk),
        .resetn      (resetn),
        .inStrobe    (inStrobe),
        .fragment    (fragment),
        .renderState (renderState),
        .outValid    (outValid),
        .bounceValid (bounceValid),
        .pixel       (pixel),
        .bounce      (bounce)
    );

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic checkValue(input string what, input logic [255:0] actual,
                              input logic [255:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "simulation stopped");
        end
    endtask

    task automatic failRun(input string reason);
        $display("Error at %0t: %s", $time, reason);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
        return bits;
    endfunction

    // Direction axis within about +-2.0 so the mirror math cannot overflow
    function automatic fixedPkg::fixedT randomAxis();
        logic [31:0] raw;
        raw = takeBits(18);
        return {{14{raw[17]}}, raw[17:0]};
    endfunction

    function automatic shadePkg::shadeFragmentT makeRandomFragment();
        shadePkg::shadeFragmentT f;
        logic [31:0]             raw;
        f.x         = takeBits(10);
        f.y         = takeBits(10);
        raw         = takeBits(2);
        f.surface   = shadePkg::surfaceT'(raw[1:0]);
        f.shadow    = takeBits(2) == 0;
        f.normal    = unitVector(int'(takeBits(3)));
        f.viewDir.x = randomAxis();
        f.viewDir.y = randomAxis();
        f.viewDir.z = randomAxis();
        f.hitPos.x  = takeBits(32);
        f.hitPos.y  = takeBits(32);
        f.hitPos.z  = takeBits(32);
        f.color     = takeBits(24);
        f.lastColor = takeBits(24);
        f.bounceLevel = takeBits(3);
        f.primIndex = takeBits(16);
        return f;
    endfunction

    function automatic shadePkg::shadeFragmentT directedFragment(input shadePkg::surfaceT s,
        input int normalIdx, input logic shadow, input int level);
        shadePkg::shadeFragmentT f;
        f             = makeRandomFragment();
        f.surface     = s;
        f.normal      = unitVector(normalIdx);
        f.shadow      = shadow;
        f.bounceLevel = level;
        return f;
    endfunction

    // Drive one fragment and queue what should come out
    task automatic driveFragment(input shadePkg::shadeFragmentT f);
        expectedT e;
        e          = shadeModel(f, renderState);
        e.dueCycle = cycleCount + shadePkg::shadeLatency;
        expQ.push_back(e);
        fragment    = f;
        inStrobe    = 1'b1;
        @(posedge clk);
        #1;
        inStrobe = 1'b0;
    endtask

    task automatic idleCycle();
        inStrobe = 1'b0;
        @(posedge clk);
        #1;
    endtask

    // --------------------
    // Checker
    // --------------------
    always @(negedge clk) begin
        if (resetn === 1'b1) begin
            if (outValid === 1'b1 || bounceValid === 1'b1) begin
                if (expQ.size() == 0) begin
                    failRun("an output strobe arrived with no fragment in flight");
                end else begin
                    gotExp = expQ.pop_front();
                    checkValue("output cycle", cycleCount, gotExp.dueCycle);
                    checkValue("bounceValid", bounceValid, gotExp.isBounce);
                    checkValue("outValid", outValid, !gotExp.isBounce);
                    if (gotExp.isBounce) begin
                        checkValue("bounce x", bounce.x, gotExp.bounce.x);
                        checkValue("bounce y", bounce.y, gotExp.bounce.y);
                        checkValue("bounce lastColor", bounce.lastColor, gotExp.bounce.lastColor);
                        checkValue("bounce level", bounce.bounceLevel, gotExp.bounce.bounceLevel);
                        checkValue("bounce orig", bounce.orig, gotExp.bounce.orig);
                        checkValue("bounce dir", bounce.dir, gotExp.bounce.dir);
                        checkValue("bounce primIndex", bounce.primIndex, gotExp.bounce.primIndex);
                    end else begin
                        checkValue("pixel x", pixel.x, gotExp.pixel.x);
                        checkValue("pixel y", pixel.y, gotExp.pixel.y);
                        checkValue("pixel color", pixel.color, gotExp.pixel.color);
                    end
                end
            end else if (expQ.size() != 0 && expQ[0].dueCycle <= cycleCount) begin
                failRun("an expected output did not appear at its due cycle");
            end
        end
    end

    initial begin
        #(watchdogNs);
        failRun("the watchdog expired before all outputs arrived");
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        inStrobe                   = 1'b0;
        fragment                   = '0;
        renderState.lightDir       = unitVector(6);
        renderState.maxBounceLevel = 4'd3;

        // Quiet outputs after reset, nothing driven yet
        @(posedge resetn);
        repeat (4) @(posedge clk);
        #1;

        // Misses, lit, clamped, shadowed, back-facing and dielectric
        driveFragment(directedFragment(shadePkg::surfaceNone, 0, 1'b0, 0));
        driveFragment(directedFragment(shadePkg::surfaceDiffuse, 6, 1'b0, 0));
        driveFragment(directedFragment(shadePkg::surfaceDiffuse, 0, 1'b0, 0));
        driveFragment(directedFragment(shadePkg::surfaceDiffuse, 0, 1'b1, 0));
        driveFragment(directedFragment(shadePkg::surfaceDiffuse, 1, 1'b0, 0));
        driveFragment(directedFragment(shadePkg::surfaceDielectric, 4, 1'b0, 2));
        // Metal below and at the bounce limit
        driveFragment(directedFragment(shadePkg::surfaceMetal, 2, 1'b0, 0));
        driveFragment(directedFragment(shadePkg::surfaceMetal, 7, 1'b0, 2));
        driveFragment(directedFragment(shadePkg::surfaceMetal, 5, 1'b0, 3));
        driveFragment(directedFragment(shadePkg::surfaceNone, 3, 1'b0, 5));

        // Back to back
        for (int i = 0; i < burstLength; i++) begin
            driveFragment(makeRandomFragment());
        end

        // Random idle gaps
        for (int i = 0; i < mixedSlots; i++) begin
            if (takeBits(2) != 0) begin
                driveFragment(makeRandomFragment());
            end else begin
                idleCycle();
            end
        end

        // Trailing cycles catch any output beyond the last fragment
        wait (expQ.size() == 0);
        repeat (4) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- files.f
hdl/fixedPkg.sv
hdl/shadePkg.sv
hdl/surfaceLight.sv
hdl/colorLane.sv
hdl/shadeOutput.sv
hdl/shadeTop.sv
+incdir+dv
dv/clockGen.sv
dv/shadeTb.sv
